// ==== common/exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;   // x0 always reads zero

    typedef enum logic [3:0] {
        alu_add   = 4'd0,
        alu_sub   = 4'd1,
        alu_sll   = 4'd2,
        alu_slt   = 4'd3,
        alu_sltu  = 4'd4,
        alu_xor   = 4'd5,
        alu_srl   = 4'd6,
        alu_sra   = 4'd7,
        alu_or    = 4'd8,
        alu_and   = 4'd9,
        alu_pass2 = 4'd10   // b straight through, for lui
    } alu_op_t;

    // operand source
    typedef enum logic [1:0] {
        src_reg = 2'd0,
        src_imm = 2'd1,
        src_pc  = 2'd2
    } src_sel_t;

    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_jal  = 4'd1,
        br_jalr = 4'd2,
        br_beq  = 4'd3,
        br_bne  = 4'd4,
        br_blt  = 4'd5,
        br_bge  = 4'd6,
        br_bltu = 4'd7,
        br_bgeu = 4'd8
    } branch_op_t;

    // multiply/divide, signedness comes separately
    typedef enum logic [2:0] {
        md_none = 3'd0,
        md_mul  = 3'd1,   // low product word
        md_mulh = 3'd2,   // high product word
        md_div  = 3'd3,
        md_rem  = 3'd4
    } md_op_t;

endpackage

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  exe_pkg::alu_op_t op,
    input  exe_pkg::word_t   a,
    input  exe_pkg::word_t   b,
    output exe_pkg::word_t   result
);

    import exe_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];   // only the low 5 bits count
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_slt: begin
                result = {{(xlen - 1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result = {{(xlen - 1){1'b0}}, lt_unsigned};
            end
            alu_xor: result = a ^ b;
            alu_srl: result = a >> shamt;
            alu_sra: begin
                result = word_t'($signed(a) >>> shamt);   // sign fill
            end
            alu_or:    result = a | b;
            alu_and:   result = a & b;
            alu_pass2: result = b;
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/branch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input  exe_pkg::branch_op_t op,
    input  exe_pkg::word_t      rs1,
    input  exe_pkg::word_t      rs2,
    output logic                taken,
    output logic                is_jump
);

    import exe_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    // one set of compares shared by all branch kinds
    assign eq   = rs1 == rs2;
    assign lt_s = $signed(rs1) < $signed(rs2);
    assign lt_u = rs1 < rs2;

    assign is_jump = (op == br_jal) || (op == br_jalr);   // link value pc+4

    always_comb begin
        case (op)
            br_jal, br_jalr: taken = 1'b1;   // unconditional
            br_beq:  taken = eq;
            br_bne:  taken = !eq;
            br_blt:  taken = lt_s;
            br_bge:  taken = !lt_s;
            br_bltu: taken = lt_u;
            br_bgeu: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== muldiv/iter_mul.sv ====
`timescale 1ns/10ps
`default_nettype none

module iter_mul #(
    parameter int width = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  logic                 is_signed,
    input  logic [width-1:0]     a,
    input  logic [width-1:0]     b,
    output logic                 busy,
    output logic                 done,
    output logic [2*width-1:0]   product
);

    localparam int cnt_w = $clog2(width + 1);

    logic [width-1:0]   a_mag;
    logic [width-1:0]   b_mag;
    logic [2*width-1:0] mcand;    // multiplicand, shifted up each step
    logic [width-1:0]   mplier;   // multiplier, shifted down each step
    logic [cnt_w-1:0]   count;
    logic               neg;

    assign a_mag = (is_signed && a[width-1]) ? -a : a;
    assign b_mag = (is_signed && b[width-1]) ? -b : b;

    // control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
            end else if (busy && count == cnt_w'(width)) begin
                busy <= 1'b0;   // sign fix cycle
                done <= 1'b1;
            end
        end
    end

    // datapath, bit 0 is consumed in the load cycle
    always_ff @(posedge clk) begin
        if (start) begin
            product <= b_mag[0] ? {{width{1'b0}}, a_mag} : '0;
            mcand   <= {{(width - 1){1'b0}}, a_mag, 1'b0};
            mplier  <= b_mag >> 1;
            count   <= cnt_w'(1);
            neg     <= is_signed && (a[width-1] ^ b[width-1]);
        end else if (busy) begin
            if (count == cnt_w'(width)) begin
                if (neg) product <= -product;
            end else begin
                if (mplier[0]) product <= product + mcand;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
                count  <= count + 1'b1;
            end
        end
    end

    start_idle_a: assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy);

endmodule

`default_nettype wire

// ==== muldiv/iter_div.sv ====
`timescale 1ns/10ps
`default_nettype none

module iter_div #(
    parameter int width = 32
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             start,
    input  logic             is_signed,
    input  logic [width-1:0] dividend,
    input  logic [width-1:0] divisor,
    output logic             busy,
    output logic             done,
    output logic [width-1:0] quotient,
    output logic [width-1:0] remainder
);

    localparam int cnt_w = $clog2(width + 1);

    logic [width-1:0] dvd_mag;
    logic [width-1:0] dvs_mag;
    logic [width-1:0] dvsr;
    logic [width:0]   rem_shift;   // partial remainder with next dividend bit
    logic [width:0]   diff;
    logic [cnt_w-1:0] count;
    logic             neg_q;
    logic             neg_r;

    assign dvd_mag = (is_signed && dividend[width-1]) ? -dividend : dividend;
    assign dvs_mag = (is_signed && divisor[width-1]) ? -divisor : divisor;

    assign rem_shift = {remainder, quotient[width-1]};
    assign diff      = rem_shift - {1'b0, dvsr};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
            end else if (busy && count == cnt_w'(width)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // quotient reg starts as the dividend and fills from the bottom
    always_ff @(posedge clk) begin
        if (start) begin
            quotient  <= dvd_mag;
            remainder <= '0;
            dvsr      <= dvs_mag;
            count     <= '0;
            // divide by zero keeps the all-ones quotient unsigned
            neg_q     <= is_signed && (dividend[width-1] ^ divisor[width-1]) && (divisor != '0);
            neg_r     <= is_signed && dividend[width-1];   // remainder follows dividend
        end else if (busy) begin
            if (count == cnt_w'(width)) begin
                // min / -1 wraps back to min here, remainder already 0
                if (neg_q) quotient <= -quotient;
                if (neg_r) remainder <= -remainder;
            end else begin
                if (!diff[width]) begin
                    remainder <= diff[width-1:0];
                    quotient  <= {quotient[width-2:0], 1'b1};
                end else begin
                    remainder <= rem_shift[width-1:0];   // restore
                    quotient  <= {quotient[width-2:0], 1'b0};
                end
                count <= count + 1'b1;
            end
        end
    end

    start_idle_a: assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy);

endmodule

`default_nettype wire

// ==== exe/exe_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module exe_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  exe_pkg::word_t      pc,
    input  exe_pkg::word_t      imm,
    input  exe_pkg::word_t      rs1_data,
    input  exe_pkg::word_t      rs2_data,
    input  exe_pkg::reg_idx_t   rs1_idx,
    input  exe_pkg::reg_idx_t   rs2_idx,
    input  exe_pkg::reg_idx_t   rd_idx,
    input  logic                rd_we,
    input  exe_pkg::alu_op_t    alu_op,
    input  exe_pkg::src_sel_t   src1_sel,
    input  exe_pkg::src_sel_t   src2_sel,
    input  exe_pkg::branch_op_t branch_op,
    input  exe_pkg::md_op_t     md_op,
    input  logic                md_signed,
    input  logic                mem_fwd_en,
    input  exe_pkg::reg_idx_t   mem_fwd_idx,
    input  exe_pkg::word_t      mem_fwd_data,
    output logic                out_valid,
    input  logic                out_ready,
    output exe_pkg::word_t      out_pc,
    output exe_pkg::reg_idx_t   out_rd_idx,
    output logic                out_rd_we,
    output exe_pkg::word_t      out_result,
    output exe_pkg::word_t      out_store_data,
    output logic                exe_fwd_en,
    output exe_pkg::reg_idx_t   exe_fwd_idx,
    output exe_pkg::word_t      exe_fwd_data,
    output logic                branch_taken,
    output exe_pkg::word_t      branch_target
);

    import exe_pkg::*;

    word_t             rs1_fwd, rs2_fwd, op_a, op_b, alu_result, result, md_result;
    logic              taken, is_jump, is_md, is_mul_op, md_start, md_pending, md_ready;
    logic              mul_busy, mul_done, div_busy, div_done, in_fire;
    logic [2*xlen-1:0] product;
    word_t             quotient, remainder;

    // bypass from memory stage, x0 never forwarded
    assign rs1_fwd = (mem_fwd_en && mem_fwd_idx == rs1_idx && rs1_idx != '0) ? mem_fwd_data
                                                                              : rs1_data;
    assign rs2_fwd = (mem_fwd_en && mem_fwd_idx == rs2_idx && rs2_idx != '0) ? mem_fwd_data
                                                                              : rs2_data;

    always_comb begin
        case (src1_sel)
            src_imm: op_a = imm;
            src_pc:  op_a = pc;
            default: op_a = rs1_fwd;
        endcase
        case (src2_sel)
            src_imm: op_b = imm;
            src_pc:  op_b = pc;
            default: op_b = rs2_fwd;
        endcase
    end

    alu alu_i (.op(alu_op), .a(op_a), .b(op_b), .result(alu_result));

    branch_unit branch_unit_i (
        .op(branch_op), .rs1(rs1_fwd), .rs2(rs2_fwd), .taken(taken), .is_jump(is_jump)
    );

    assign branch_taken  = in_valid && taken;
    assign branch_target = op_a + op_b;   // pc+imm or rs1+imm

    assign is_md     = md_op != md_none;
    assign is_mul_op = (md_op == md_mul) || (md_op == md_mulh);
    assign md_start  = in_valid && is_md && !md_pending && !md_ready;   // one cycle only

    iter_mul #(.width(xlen)) iter_mul_i (
        .clk(clk), .arst_n(arst_n), .start(md_start && is_mul_op), .is_signed(md_signed),
        .a(op_a), .b(op_b), .busy(mul_busy), .done(mul_done), .product(product)
    );

    iter_div #(.width(xlen)) iter_div_i (
        .clk(clk), .arst_n(arst_n), .start(md_start && !is_mul_op), .is_signed(md_signed),
        .dividend(op_a), .divisor(op_b), .busy(div_busy), .done(div_done),
        .quotient(quotient), .remainder(remainder)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            md_pending <= 1'b0;
            md_ready   <= 1'b0;
        end else begin
            if (md_start) md_pending <= 1'b1;
            else if (mul_done || div_done) md_pending <= 1'b0;
            if (mul_done || div_done) md_ready <= 1'b1;
            else if (in_fire) md_ready <= 1'b0;   // consumed by the output register
        end
    end

    always_ff @(posedge clk) begin
        if (mul_done) md_result <= (md_op == md_mulh) ? product[2*xlen-1:xlen] : product[xlen-1:0];
        else if (div_done) md_result <= (md_op == md_rem) ? remainder : quotient;
    end

    assign result = is_jump ? pc + 32'd4 : (is_md ? md_result : alu_result);

    assign in_ready = (!out_valid || out_ready) && (!is_md || md_ready);
    assign in_fire  = in_valid && in_ready;

    // md results are not ready in the cycle they launch
    assign exe_fwd_en   = in_valid && rd_we && !is_md;
    assign exe_fwd_idx  = rd_idx;
    assign exe_fwd_data = result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) out_valid <= 1'b0;
        else if (in_fire) out_valid <= 1'b1;
        else if (out_ready) out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_pc         <= pc;
            out_rd_idx     <= rd_idx;
            out_rd_we      <= rd_we;
            out_result     <= result;
            out_store_data <= rs2_fwd;
        end
    end

    out_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_result));
    in_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid);
    // pending flag only while a unit is running or reporting done
    md_busy_a: assert property (@(posedge clk) disable iff (!arst_n)
        md_pending |-> mul_busy || div_busy || mul_done || div_done);

endmodule

`default_nettype wire

// ==== test/tb_exe_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_exe_stage;

    import exe_pkg::*;

    localparam int max_wait = 100;

    logic       clk, arst_n, in_valid, in_ready, rd_we, md_signed, mem_fwd_en;
    logic       out_valid, out_ready, out_rd_we, exe_fwd_en, branch_taken;
    word_t      pc, imm, rs1_data, rs2_data, mem_fwd_data, out_pc, out_result;
    word_t      out_store_data, exe_fwd_data, branch_target;
    reg_idx_t   rs1_idx, rs2_idx, rd_idx, mem_fwd_idx, out_rd_idx, exe_fwd_idx;
    alu_op_t    alu_op;
    src_sel_t   src1_sel, src2_sel;
    branch_op_t branch_op;
    md_op_t     md_op;
    integer     seed;
    int         low_cycles;   // negedges spent waiting with in_ready low

    exe_stage exe_stage_i (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic report_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // sign bits decide when they differ
    function automatic logic signed_less(input word_t a, input word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 32'd1;
            alu_sll:  return a << b[4:0];
            alu_slt:  return signed_less(a, b) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[4:0];
            alu_sra:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            alu_or:   return a | b;
            alu_and:  return a & b;
            default:  return b;   // pass2
        endcase
    endfunction

    function automatic logic model_taken(input branch_op_t op, input word_t a, input word_t b);
        case (op)
            br_jal, br_jalr: return 1'b1;
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return signed_less(a, b);
            br_bge:  return !signed_less(a, b);
            br_bltu: return a < b;
            br_bgeu: return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t model_md(input md_op_t op, input logic sgn, input word_t a, b);
        logic [63:0] p;
        if (op == md_mul || op == md_mulh) begin
            if (sgn) p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            else p = {32'd0, a} * {32'd0, b};
            return (op == md_mul) ? p[31:0] : p[63:32];
        end
        if (b == '0) return (op == md_div) ? '1 : a;
        if (sgn && a == 32'h8000_0000 && b == '1) return (op == md_div) ? a : '0;
        if (sgn) return (op == md_div) ? $signed(a) / $signed(b) : $signed(a) % $signed(b);
        return (op == md_div) ? a / b : a % b;
    endfunction

    task automatic drive_op(input word_t p, im, r1, r2, input reg_idx_t i1, i2,
                            input alu_op_t aop, input src_sel_t s1, s2, input branch_op_t bop,
                            input md_op_t mop, input logic sgn, fen, input reg_idx_t fidx,
                            input word_t fdata);
        @(posedge clk);
        in_valid     <= 1'b1;
        pc           <= p;
        imm          <= im;
        rs1_data     <= r1;
        rs2_data     <= r2;
        rs1_idx      <= i1;
        rs2_idx      <= i2;
        rd_idx       <= 5'($random(seed));
        rd_we        <= 1'($random(seed));
        alu_op       <= aop;
        src1_sel     <= s1;
        src2_sel     <= s2;
        branch_op    <= bop;
        md_op        <= mop;
        md_signed    <= sgn;
        mem_fwd_en   <= fen;
        mem_fwd_idx  <= fidx;
        mem_fwd_data <= fdata;
    endtask

    task automatic wait_ready;
        low_cycles = 0;
        do begin
            @(negedge clk);
            if (!in_ready) low_cycles++;
            if (low_cycles > max_wait) report_error("timeout waiting for in_ready");
        end while (!in_ready);
    endtask

    task automatic send_op(input word_t p, im, r1, r2, input reg_idx_t i1, i2,
                           input alu_op_t aop, input src_sel_t s1, s2, input branch_op_t bop,
                           input md_op_t mop, input logic sgn, fen, input reg_idx_t fidx,
                           input word_t fdata);
        drive_op(p, im, r1, r2, i1, i2, aop, s1, s2, bop, mop, sgn, fen, fidx, fdata);
        wait_ready;
    endtask

    // the next rising edge is the input transfer
    task automatic wait_out;
        int n;
        @(posedge clk);
        in_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > max_wait) report_error("timeout waiting for out_valid");
        end while (!out_valid);
    endtask

    task automatic test_alu;
        word_t a, b, exp;
        for (int op = 0; op <= 10; op++) begin
            a = $random(seed);
            b = $random(seed);
            exp = model_alu(alu_op_t'(op), a, b);
            send_op(32'h100, '0, a, b, 5'd1, 5'd2, alu_op_t'(op), src_reg, src_reg, br_none,
                    md_none, 1'b0, 1'b0, 5'd0, '0);
            check_bit("exe_fwd_en", exe_fwd_en, rd_we);
            check_idx("exe_fwd_idx", exe_fwd_idx, rd_idx);
            check_word("exe_fwd_data", exe_fwd_data, exp);
            wait_out;
            check_word("out_result", out_result, exp);
            check_idx("out_rd_idx", out_rd_idx, rd_idx);
            check_bit("out_rd_we", out_rd_we, rd_we);
            check_bit("exe_fwd_en", exe_fwd_en, 1'b0);   // in_valid low now
        end
    endtask

    task automatic test_fwd;
        word_t a, b, im, fd, ea, eb;
        reg_idx_t i1, i2, fi;
        // 0 rs1 hit, 1 rs2 hit, 2 index zero, 3 enable low, 4 no match
        for (int k = 0; k < 5; k++) begin
            a = $random(seed);
            b = $random(seed);
            fd = $random(seed);
            i1 = (k == 2) ? 5'd0 : 5'd3;
            i2 = (k == 2) ? 5'd0 : 5'd4;
            fi = (k == 0 || k == 3) ? 5'd3 : (k == 1) ? 5'd4 : (k == 2) ? 5'd0 : 5'd9;
            ea = (k == 0) ? fd : a;
            eb = (k == 1) ? fd : b;
            send_op(32'h200, '0, a, b, i1, i2, alu_xor, src_reg, src_reg, br_none, md_none,
                    1'b0, k != 3, fi, fd);
            wait_out;
            check_word("out_result", out_result, ea ^ eb);
            check_word("out_store_data", out_store_data, eb);
        end
        im = $random(seed);
        send_op(32'h340, im, a, b, 5'd1, 5'd2, alu_sub, src_pc, src_imm, br_none, md_none,
                1'b0, 1'b0, 5'd0, '0);
        wait_out;
        check_word("out_result", out_result, 32'h340 - im);
        check_word("out_pc", out_pc, 32'h340);
        send_op(32'h344, im, a, b, 5'd1, 5'd2, alu_add, src_reg, src_imm, br_none, md_none,
                1'b0, 1'b0, 5'd0, '0);
        wait_out;
        check_word("out_result", out_result, a + im);
    endtask

    task automatic test_branch;
        word_t x, y, im, tgt;
        src_sel_t s1;
        for (int op = 1; op <= 8; op++) begin
            for (int t = 0; t < 2; t++) begin
                im = $random(seed);
                // top bit set on one side splits signed from unsigned order
                x = (op <= 4) ? 32'd5 : (t == 0) ? 32'h8000_0010 : 32'h0000_0020;
                y = (op <= 4) ? ((t == 0) ? 32'd5 : 32'd6)
                              : ((t == 0) ? 32'h0000_0020 : 32'h8000_0010);
                s1 = (op == 2) ? src_reg : src_pc;
                tgt = (op == 2) ? x + im : 32'h1000 + im;
                send_op(32'h1000, im, x, y, 5'd1, 5'd2, alu_add, s1, src_imm,
                        branch_op_t'(op), md_none, 1'b0, 1'b0, 5'd0, '0);
                check_bit("branch_taken", branch_taken, model_taken(branch_op_t'(op), x, y));
                check_word("branch_target", branch_target, tgt);
                wait_out;
                check_word("out_result", out_result, (op <= 2) ? 32'h1004 : tgt);
                check_bit("branch_taken", branch_taken, 1'b0);   // no redirect without in_valid
            end
        end
    endtask

    task automatic test_md;
        word_t a, b, exp;
        md_op_t mop;
        logic sgn;
        int min_low;
        for (int k = 0; k < 20; k++) begin
            a = $random(seed);
            b = $random(seed);
            mop = (k < 16) ? md_op_t'(1 + k % 4) : md_op_t'(3 + k % 2);
            sgn = (k < 16) ? ((k / 4) % 2 == 1) : (k != 17);
            if (k == 16 || k == 17) b = '0;   // divide by zero
            if (k >= 18) begin
                a = 32'h8000_0000;
                b = '1;
            end
            exp = model_md(mop, sgn, a, b);
            // unit latency, then one cycle to latch the result
            min_low = (mop == md_mul || mop == md_mulh) ? xlen + 2 : xlen + 3;
            send_op(32'h500, '0, a, b, 5'd1, 5'd2, alu_add, src_reg, src_reg, br_none, mop,
                    sgn, 1'b0, 5'd0, '0);
            if (low_cycles < min_low)
                report_error("in_ready rose before the unit result was ready");
            check_bit("exe_fwd_en", exe_fwd_en, 1'b0);
            wait_out;
            check_word("out_result", out_result, exp);
        end
    endtask

    task automatic test_backpressure;
        word_t a, b;
        a = $random(seed);
        b = $random(seed);
        @(posedge clk);
        out_ready <= 1'b0;
        send_op(32'h600, '0, a, b, 5'd1, 5'd2, alu_add, src_reg, src_reg, br_none, md_none,
                1'b0, 1'b0, 5'd0, '0);
        wait_out;
        drive_op(32'h604, '0, a, b, 5'd1, 5'd2, alu_sub, src_reg, src_reg, br_none, md_none,
                 1'b0, 1'b0, 5'd0, '0);
        repeat (5) begin
            @(negedge clk);
            check_bit("out_valid", out_valid, 1'b1);
            check_word("out_result", out_result, a + b);
            check_bit("in_ready", in_ready, 1'b0);
        end
        @(posedge clk);
        out_ready <= 1'b1;
        wait_ready;
        wait_out;
        check_word("out_result", out_result, a - b);
        check_word("out_pc", out_pc, 32'h604);
    endtask

    initial begin
        seed = 32'hd69df5c6;
        arst_n = 1'b0;
        in_valid = 1'b0;
        pc = '0;
        imm = '0;
        rs1_data = '0;
        rs2_data = '0;
        rs1_idx = '0;
        rs2_idx = '0;
        rd_idx = '0;
        rd_we = 1'b0;
        alu_op = alu_add;
        src1_sel = src_reg;
        src2_sel = src_reg;
        branch_op = br_none;
        md_op = md_none;
        md_signed = 1'b0;
        mem_fwd_en = 1'b0;
        mem_fwd_idx = '0;
        mem_fwd_data = '0;
        out_ready = 1'b1;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
        test_alu;
        test_fwd;
        test_branch;
        test_md;
        test_backpressure;
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/exe_pkg.sv
logic/alu.sv
logic/branch_unit.sv
muldiv/iter_mul.sv
muldiv/iter_div.sv
exe/exe_stage.sv
test/tb_exe_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the exe_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_exe_stage -f filelist.f || exit 1
out=$(./obj_dir/Vtb_exe_stage)
echo "$out"
echo "$out" | grep -q "Simulation passed" && exit 0 || exit 1
